/* design/harness_cfg.svh */
// Sizes, address map and fixed constants of the memory-mapped harness
`ifndef HARNESS_CFG_SVH
`define HARNESS_CFG_SVH

// Bus widths
`define ADDR_W             16
`define DATA_W             32

// Main memory, split into equal banks
`define NUM_BANKS          4
`define BANK_WORDS         64

// Region bases
`define ROM_BASE           16'h0000
`define ROM_WORDS          64
`define CLINT_BASE         16'h0200
`define RAM_BASE           16'h1000

`define ROM_TAG            16'hB007
`define DEBUG_DELAY_CYCLES 20

`endif

/* design/harness_pkg.sv */
// Bus types and address region encoding
`include "harness_cfg.svh"

package harness_pkg;

  // Byte address and data word
  typedef logic [`ADDR_W-1:0]   addr_t;
  typedef logic [`DATA_W-1:0]   data_t;
  typedef logic [`DATA_W/8-1:0] be_t;

  // Bank select and word index inside a bank or the ROM
  typedef logic [$clog2(`NUM_BANKS)-1:0]  bank_idx_t;
  typedef logic [$clog2(`BANK_WORDS)-1:0] word_idx_t;

  // Target of a decoded request
  typedef enum logic [1:0] {
    REGION_ROM   = 2'd0,
    REGION_RAM   = 2'd1,
    REGION_CLINT = 2'd2,
    REGION_ERR   = 2'd3
  } region_e;

endpackage

/* design/addr_decoder.sv */
// Address decoder with target selects and registered response routing
`timescale 1ns/1ps
`include "harness_cfg.svh"

module addr_decoder import harness_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_i,
  input  logic                  we_i,
  input  addr_t                 addr_i,
  output logic [`NUM_BANKS-1:0] bank_req_o,
  output logic                  rom_req_o,
  output logic                  clint_req_o,
  output logic                  rsp_valid_o,
  output region_e               rsp_region_o,
  output bank_idx_t             rsp_bank_o,
  output logic                  we_q_o
);

  localparam int BYTE_OFS   = $clog2(`DATA_W/8);
  localparam int ROM_SPAN   = $clog2(`ROM_WORDS) + BYTE_OFS;
  localparam int RAM_SPAN   = $clog2(`NUM_BANKS * `BANK_WORDS) + BYTE_OFS;
  localparam int CLINT_SPAN = 2 + BYTE_OFS;
  localparam addr_t ROM_BASE_A   = `ROM_BASE;
  localparam addr_t RAM_BASE_A   = `RAM_BASE;
  localparam addr_t CLINT_BASE_A = `CLINT_BASE;

  region_e   region;
  bank_idx_t bank;

  assign bank = addr_i[BYTE_OFS + $bits(word_idx_t) +: $bits(bank_idx_t)];

  // ----------------------------------------
  // Region match
  // ----------------------------------------
  always_comb begin
    region = REGION_ERR;
    if (addr_i[`ADDR_W-1:ROM_SPAN] == ROM_BASE_A[`ADDR_W-1:ROM_SPAN]) begin
      // ROM is read-only
      region = we_i ? REGION_ERR : REGION_ROM;
    end else if (addr_i[`ADDR_W-1:CLINT_SPAN] == CLINT_BASE_A[`ADDR_W-1:CLINT_SPAN]) begin
      region = REGION_CLINT;
    end else if (addr_i[`ADDR_W-1:RAM_SPAN] == RAM_BASE_A[`ADDR_W-1:RAM_SPAN]) begin
      region = REGION_RAM;
    end
  end

  always_comb begin
    bank_req_o = '0;
    if (req_i && region == REGION_RAM) begin
      bank_req_o[bank] = 1'b1;
    end
  end

  assign rom_req_o   = req_i && region == REGION_ROM;
  assign clint_req_o = req_i && region == REGION_CLINT;

  // Routing for the response one cycle later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_o  <= 1'b0;
      rsp_region_o <= REGION_ERR;
      rsp_bank_o   <= '0;
      we_q_o       <= 1'b0;
    end else begin
      rsp_valid_o  <= req_i;
      rsp_region_o <= region;
      rsp_bank_o   <= bank;
      we_q_o       <= we_i;
    end
  end

  a_one_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({bank_req_o, rom_req_o, clint_req_o}));

endmodule

/* design/sram_bank.sv */
// Single RAM bank with byte-enabled writes and registered reads
`timescale 1ns/1ps
`include "harness_cfg.svh"

module sram_bank import harness_pkg::*; (
  input  logic      clk_i,
  input  logic      req_i,
  input  logic      we_i,
  input  word_idx_t word_i,
  input  be_t       be_i,
  input  data_t     wdata_i,
  output data_t     rdata_o
);

  data_t mem_q [`BANK_WORDS];
  data_t rdata_q;

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int i = 0; i < $bits(be_t); i++) begin
          if (be_i[i]) begin
            mem_q[word_i][8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[word_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* design/boot_rom.sv */
// Boot ROM with fixed tagged contents and registered read data
`timescale 1ns/1ps
`include "harness_cfg.svh"

module boot_rom import harness_pkg::*; (
  input  logic      clk_i,
  input  logic      req_i,
  input  word_idx_t word_i,
  output data_t     rdata_o
);

  localparam int HALF_W = `DATA_W / 2;

  data_t rom_table [`ROM_WORDS];
  data_t rdata_q;

  // Upper half is the tag, lower half the word index
  for (genvar k = 0; k < `ROM_WORDS; k++) begin : g_word
    assign rom_table[k] = {`ROM_TAG, HALF_W'(k)};
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= rom_table[word_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* design/clint_timer.sv */
// Core-local timer: mtime counter driven by rtc, mtimecmp compare
// and the software interrupt bit
`timescale 1ns/1ps

module clint_timer import harness_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req_i,
  input  logic       we_i,
  input  logic [1:0] reg_i,
  input  data_t      wdata_i,
  input  logic       rtc_i,
  output data_t      rdata_o,
  output logic       timer_irq_o,
  output logic       ipi_o
);

  localparam logic [1:0] MSIP_OFS     = 2'd0;
  localparam logic [1:0] MTIMECMP_OFS = 2'd1;
  localparam logic [1:0] MTIME_OFS    = 2'd2;

  logic  msip_q;
  data_t mtimecmp_q;
  data_t mtime_q;
  logic  rtc_q;
  logic  rtc_rise;
  data_t rdata_q;

  assign rtc_rise = rtc_i & ~rtc_q;

  // ----------------------------------------
  // Registers
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      msip_q     <= 1'b0;
      mtimecmp_q <= '1;
      mtime_q    <= '0;
      rtc_q      <= 1'b0;
    end else begin
      rtc_q <= rtc_i;
      if (rtc_rise) begin
        mtime_q <= mtime_q + 1'b1;
      end
      // mtime is read-only from the bus
      if (req_i && we_i) begin
        case (reg_i)
          MSIP_OFS:     msip_q     <= wdata_i[0];
          MTIMECMP_OFS: mtimecmp_q <= wdata_i;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      case (reg_i)
        MSIP_OFS:     rdata_q <= data_t'(msip_q);
        MTIMECMP_OFS: rdata_q <= mtimecmp_q;
        MTIME_OFS:    rdata_q <= mtime_q;
        default:      rdata_q <= '0;
      endcase
    end
  end

  assign rdata_o     = rdata_q;
  assign timer_irq_o = mtime_q >= mtimecmp_q;
  assign ipi_o       = msip_q;

endmodule

/* design/resp_mux.sv */
// Response multiplexer over banks, ROM and timer with error flag
`timescale 1ns/1ps
`include "harness_cfg.svh"

module resp_mux import harness_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      rsp_valid_i,
  input  region_e   rsp_region_i,
  input  bank_idx_t rsp_bank_i,
  input  data_t     bank_rdata_i [`NUM_BANKS],
  input  data_t     rom_rdata_i,
  input  data_t     clint_rdata_i,
  input  logic      we_q_i,
  output logic      rvalid_o,
  output logic      err_o,
  output data_t     rdata_o
);

  assign rvalid_o = rsp_valid_i;
  assign err_o    = rsp_valid_i && rsp_region_i == REGION_ERR;

  // Writes and errors return zero data
  always_comb begin
    rdata_o = '0;
    if (rsp_valid_i && !we_q_i) begin
      case (rsp_region_i)
        REGION_RAM:   rdata_o = bank_rdata_i[rsp_bank_i];
        REGION_ROM:   rdata_o = rom_rdata_i;
        REGION_CLINT: rdata_o = clint_rdata_i;
        default:      rdata_o = '0;
      endcase
    end
  end

  a_err_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    err_o |-> rvalid_o && rdata_o == '0);

endmodule

/* design/debug_gate.sv */
// Debug request gate with hold-off window after reset
`timescale 1ns/1ps
`include "harness_cfg.svh"

module debug_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  input  logic debug_enable_i,
  output logic debug_req_o
);

  localparam int CNT_W = $clog2(`DEBUG_DELAY_CYCLES + 1);

  logic [CNT_W-1:0] cnt_q;

  // Counts down once and stays at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= CNT_W'(`DEBUG_DELAY_CYCLES);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (cnt_q == '0) && debug_req_i && debug_enable_i;

  a_hold_off: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(rst_ni) |-> !debug_req_o [* `DEBUG_DELAY_CYCLES]);

endmodule

/* design/soc_harness.sv */
// Top level: decoder, RAM banks, boot ROM, timer, response mux
// and debug request gate
`timescale 1ns/1ps
`include "harness_cfg.svh"

module soc_harness import harness_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  req_i,
  input  logic  we_i,
  input  addr_t addr_i,
  input  be_t   be_i,
  input  data_t wdata_i,
  output logic  rvalid_o,
  output data_t rdata_o,
  output logic  err_o,
  input  logic  rtc_i,
  input  logic  debug_req_i,
  input  logic  debug_enable_i,
  output logic  timer_irq_o,
  output logic  ipi_o,
  output logic  debug_req_o
);

  word_idx_t             word_idx;
  logic [1:0]            clint_reg;
  logic [`NUM_BANKS-1:0] bank_req;
  logic                  rom_req;
  logic                  clint_req;
  logic                  rsp_valid;
  region_e               rsp_region;
  bank_idx_t             rsp_bank;
  logic                  we_q;
  data_t                 bank_rdata [`NUM_BANKS];
  data_t                 rom_rdata;
  data_t                 clint_rdata;

  assign word_idx  = addr_i[$clog2(`DATA_W/8) +: $bits(word_idx_t)];
  assign clint_reg = addr_i[$clog2(`DATA_W/8) +: 2];

  addr_decoder i_decoder (
    .clk_i        ( clk_i       ),
    .rst_ni       ( rst_ni      ),
    .req_i        ( req_i       ),
    .we_i         ( we_i        ),
    .addr_i       ( addr_i      ),
    .bank_req_o   ( bank_req    ),
    .rom_req_o    ( rom_req     ),
    .clint_req_o  ( clint_req   ),
    .rsp_valid_o  ( rsp_valid   ),
    .rsp_region_o ( rsp_region  ),
    .rsp_bank_o   ( rsp_bank    ),
    .we_q_o       ( we_q        )
  );

  // ----------------------------------------
  // Main memory
  // ----------------------------------------
  for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_bank
    sram_bank i_bank (
      .clk_i   ( clk_i         ),
      .req_i   ( bank_req[b]   ),
      .we_i    ( we_i          ),
      .word_i  ( word_idx      ),
      .be_i    ( be_i          ),
      .wdata_i ( wdata_i       ),
      .rdata_o ( bank_rdata[b] )
    );
  end

  boot_rom i_rom (
    .clk_i   ( clk_i     ),
    .req_i   ( rom_req   ),
    .word_i  ( word_idx  ),
    .rdata_o ( rom_rdata )
  );

  clint_timer i_clint (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .req_i       ( clint_req   ),
    .we_i        ( we_i        ),
    .reg_i       ( clint_reg   ),
    .wdata_i     ( wdata_i     ),
    .rtc_i       ( rtc_i       ),
    .rdata_o     ( clint_rdata ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  resp_mux i_resp_mux (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .rsp_valid_i   ( rsp_valid   ),
    .rsp_region_i  ( rsp_region  ),
    .rsp_bank_i    ( rsp_bank    ),
    .bank_rdata_i  ( bank_rdata  ),
    .rom_rdata_i   ( rom_rdata   ),
    .clint_rdata_i ( clint_rdata ),
    .we_q_i        ( we_q        ),
    .rvalid_o      ( rvalid_o    ),
    .err_o         ( err_o       ),
    .rdata_o       ( rdata_o     )
  );

  debug_gate i_debug_gate (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .debug_req_i    ( debug_req_i    ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_o    ( debug_req_o    )
  );

endmodule

/* bench/tb_soc_harness.sv */
// Testbench for the memory-mapped harness: LCG bus traffic checked
// against a reference model of RAM, ROM and timer, plus debug gate
// checks, watchdog and summary
`timescale 1ns/1ps
`include "harness_cfg.svh"

module tb_soc_harness import harness_pkg::*;;

  localparam int CLK_PERIOD    = 100;
  localparam int RAM_WORDS     = `NUM_BANKS * `BANK_WORDS;
  localparam int N_RAM_OPS     = 400;
  localparam int N_ROM_OPS     = 150;
  localparam int N_TIMER_OPS   = 300;
  localparam int N_FLUSH       = 4;
  localparam int TOTAL_CYCLES  = 4 + RAM_WORDS + N_RAM_OPS + N_ROM_OPS + N_TIMER_OPS + N_FLUSH;
  localparam int MARGIN_CYCLES = 50;

  logic  clk_i = 1'b0;
  logic  rst_ni;
  logic  req_i;
  logic  we_i;
  addr_t addr_i;
  be_t   be_i;
  data_t wdata_i;
  logic  rvalid_o;
  data_t rdata_o;
  logic  err_o;
  logic  rtc_i;
  logic  debug_req_i;
  logic  debug_enable_i;
  logic  timer_irq_o;
  logic  ipi_o;
  logic  debug_req_o;

  // Reference model state
  logic [31:0] seed;
  data_t       ram_m [RAM_WORDS];
  data_t       mtime_m;
  data_t       cmp_m;
  logic        msip_m;
  logic        pend_rise;
  logic        pend_cmp_wr;
  data_t       pend_cmp;
  logic        pend_msip_wr;
  logic        pend_msip;
  logic        rtc_drv;
  logic        rtc_last;
  logic [33:0] exp_q [$];
  int          dbg_cnt;
  logic        dbg_random;
  int          dbg_low_seen;
  int          errors;
  int          checks;

  soc_harness dut_i (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .req_i          ( req_i          ),
    .we_i           ( we_i           ),
    .addr_i         ( addr_i         ),
    .be_i           ( be_i           ),
    .wdata_i        ( wdata_i        ),
    .rvalid_o       ( rvalid_o       ),
    .rdata_o        ( rdata_o        ),
    .err_o          ( err_o          ),
    .rtc_i          ( rtc_i          ),
    .debug_req_i    ( debug_req_i    ),
    .debug_enable_i ( debug_enable_i ),
    .timer_irq_o    ( timer_irq_o    ),
    .ipi_o          ( ipi_o          ),
    .debug_req_o    ( debug_req_o    )
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // ----------------------------------------
  // Random numbers and checks
  // ----------------------------------------
  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Upper bits only, the low LCG bits repeat quickly
  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = next_rand();
    return int'(r[31:12]) % n;
  endfunction

  function automatic data_t rand_word();
    logic [31:0] r1;
    logic [31:0] r2;
    r1 = next_rand();
    r2 = next_rand();
    return {r1[31:16], r2[31:16]};
  endfunction

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_word(input string what, input data_t got, input data_t exp);
    checks++;
    assert (got === exp) else begin
      $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // One bus cycle: drive after the edge, check the previous response at
  // the falling edge, then apply this cycle's timer effects to the model
  task automatic bus_cycle(input logic req, input logic we, input addr_t addr, input be_t be,
                           input data_t wdata, input logic exp_err, input data_t exp_data);
    logic [33:0] prev;
    data_t       rsp_data;
    logic        dbg_exp;
    @(posedge clk_i);
    #1;
    if (dbg_random) begin
      debug_req_i    = rand_below(2) == 1;
      debug_enable_i = rand_below(2) == 1;
    end
    req_i   = req;
    we_i    = we;
    addr_i  = addr;
    be_i    = be;
    wdata_i = wdata;
    rtc_i   = rtc_drv;
    if (rtc_drv && !rtc_last) begin
      pend_rise = 1'b1;
    end
    rtc_last = rtc_drv;
    rsp_data = (req && !we && !exp_err) ? exp_data : data_t'(0);
    exp_q.push_back({req, req && exp_err, rsp_data});

    @(negedge clk_i);
    prev = exp_q.pop_front();
    check_bit("rvalid_o", rvalid_o, prev[33]);
    check_bit("err_o", err_o, prev[32]);
    check_word("rdata_o", rdata_o, prev[31:0]);
    check_bit("timer_irq_o", timer_irq_o, mtime_m >= cmp_m);
    check_bit("ipi_o", ipi_o, msip_m);
    dbg_exp = (dbg_cnt == 0) && debug_req_i && debug_enable_i;
    check_bit("debug_req_o", debug_req_o, dbg_exp);
    if (!dbg_random && debug_req_o === 1'b0) begin
      dbg_low_seen++;
    end

    if (dbg_cnt != 0) begin
      dbg_cnt--;
    end
    if (pend_rise) begin
      mtime_m = mtime_m + 32'd1;
    end
    if (pend_cmp_wr) begin
      cmp_m = pend_cmp;
    end
    if (pend_msip_wr) begin
      msip_m = pend_msip;
    end
    pend_rise    = 1'b0;
    pend_cmp_wr  = 1'b0;
    pend_msip_wr = 1'b0;
  endtask

  task automatic idle_cycle();
    bus_cycle(1'b0, 1'b0, '0, '0, '0, 1'b0, '0);
  endtask

  task automatic ram_access(input logic we, input int w, input be_t be, input data_t wdata);
    data_t exp;
    exp = ram_m[w];
    if (we) begin
      for (int i = 0; i < $bits(be_t); i++) begin
        if (be[i]) begin
          ram_m[w][8*i +: 8] = wdata[8*i +: 8];
        end
      end
    end
    bus_cycle(1'b1, we, `RAM_BASE + addr_t'(w * 4), be, wdata, 1'b0, exp);
  endtask

  task automatic clint_access(input logic we, input logic [1:0] ofs, input data_t wdata);
    data_t exp;
    exp = '0;
    if (we) begin
      if (ofs == 2'd0) begin
        pend_msip_wr = 1'b1;
        pend_msip    = wdata[0];
      end else if (ofs == 2'd1) begin
        pend_cmp_wr = 1'b1;
        pend_cmp    = wdata;
      end
    end else begin
      case (ofs)
        2'd0:    exp = {31'b0, msip_m};
        2'd1:    exp = cmp_m;
        2'd2:    exp = mtime_m;
        default: exp = '0;
      endcase
    end
    bus_cycle(1'b1, we, `CLINT_BASE + addr_t'({ofs, 2'b00}), '1, wdata, 1'b0, exp);
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    int          kind;
    int          w;
    logic        we;
    addr_t       addr;
    logic [1:0]  ofs;
    data_t       wdata;
    seed           = 32'hd51bec50;
    rst_ni         = 1'b0;
    req_i          = 1'b0;
    we_i           = 1'b0;
    addr_i         = '0;
    be_i           = '0;
    wdata_i        = '0;
    rtc_i          = 1'b0;
    debug_req_i    = 1'b1;
    debug_enable_i = 1'b1;
    mtime_m        = '0;
    cmp_m          = '1;
    msip_m         = 1'b0;
    pend_rise      = 1'b0;
    pend_cmp_wr    = 1'b0;
    pend_cmp       = '0;
    pend_msip_wr   = 1'b0;
    pend_msip      = 1'b0;
    rtc_drv        = 1'b0;
    rtc_last       = 1'b0;
    dbg_cnt        = `DEBUG_DELAY_CYCLES;
    dbg_random     = 1'b0;
    dbg_low_seen   = 0;
    errors         = 0;
    checks         = 0;
    exp_q.push_back('0);

    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_bit("debug_req_o", debug_req_o, 1'b0);
    if (debug_req_o === 1'b0) begin
      dbg_low_seen++;
    end
    dbg_cnt--;

    // Fill pattern built from the full byte address
    for (int i = 0; i < RAM_WORDS; i++) begin
      addr = `RAM_BASE + addr_t'(i * 4);
      ram_access(1'b1, i, '1, {addr, ~addr});
    end

    checks++;
    assert (dbg_low_seen == `DEBUG_DELAY_CYCLES) else begin
      $display("FAIL %0t: debug_req_o held low for %0d cycles, expected %0d",
               $time, dbg_low_seen, `DEBUG_DELAY_CYCLES);
      errors++;
    end
    dbg_random = 1'b1;

    // RAM traffic across all banks
    for (int n = 0; n < N_RAM_OPS; n++) begin
      we = rand_below(2) == 1;
      w  = rand_below(RAM_WORDS);
      ram_access(we, w, be_t'(rand_below(16)), rand_word());
    end

    // ROM reads, ROM writes and unmapped accesses
    for (int n = 0; n < N_ROM_OPS; n++) begin
      kind = rand_below(4);
      if (kind < 2) begin
        w = rand_below(`ROM_WORDS);
        addr = `ROM_BASE + addr_t'(w * 4);
        bus_cycle(1'b1, 1'b0, addr, '1, '0, 1'b0, {`ROM_TAG, 16'(w)});
      end else if (kind == 2) begin
        addr = `ROM_BASE + addr_t'(rand_below(`ROM_WORDS) * 4);
        bus_cycle(1'b1, 1'b1, addr, '1, rand_word(), 1'b1, '0);
      end else begin
        if (rand_below(2) == 1) begin
          addr = 16'h0210 + addr_t'(rand_below(16'h0df0));
        end else begin
          addr = 16'h4000 | addr_t'(rand_below(16'h4000));
        end
        we = rand_below(2) == 1;
        bus_cycle(1'b1, we, addr, '1, rand_word(), 1'b1, '0);
      end
    end

    // Timer: rtc toggles only in cycles without a timer request
    for (int n = 0; n < N_TIMER_OPS; n++) begin
      kind = rand_below(6);
      if (kind < 2) begin
        rtc_drv = !rtc_drv;
        idle_cycle();
      end else if (kind == 2) begin
        clint_access(1'b1, 2'd1, mtime_m + data_t'(rand_below(6)));
      end else if (kind == 3) begin
        clint_access(1'b1, 2'd0, rand_word());
      end else begin
        ofs   = 2'(rand_below(4));
        we    = rand_below(4) == 0;
        wdata = rand_word();
        clint_access(we, ofs, wdata);
      end
    end

    repeat (N_FLUSH) idle_cycle();

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(CLK_PERIOD * (TOTAL_CYCLES + MARGIN_CYCLES));
    $display("Watchdog timeout: the run did not finish within %0d cycles",
             TOTAL_CYCLES + MARGIN_CYCLES);
    $display("Checks failed");
    $finish;
  end

endmodule

/* flist.f */
+incdir+design
design/harness_pkg.sv
design/addr_decoder.sv
design/sram_bank.sv
design/boot_rom.sv
design/clint_timer.sv
design/resp_mux.sv
design/debug_gate.sv
design/soc_harness.sv
bench/tb_soc_harness.sv

/* run.sh */
#!/bin/sh
# Build and run the harness testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_soc_harness -f flist.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Checks failed" "$LOG"; then
  exit 1
fi
exit 0
